/* rtl/cache_defines.svh */
// Cache geometry macros, included by the cache package and the testbench.
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Byte address bits on the processor side.
`define CACHE_ADDR_W 16

// 32-bit words per cache line.
`define CACHE_LINE_WORDS 4

// Number of sets.
`define CACHE_LINES 8

// Ways per set.
`define CACHE_WAYS 2

`endif

/* rtl/cache_pkg.sv */
// Address fields, tag entries and RAM row types shared by every cache module.
`include "cache_defines.svh"

package cache_pkg;

    localparam int ways       = `CACHE_WAYS;
    localparam int lines      = `CACHE_LINES;
    localparam int line_words = `CACHE_LINE_WORDS;
    localparam int offset_w   = $clog2(`CACHE_LINE_WORDS);
    localparam int index_w    = $clog2(`CACHE_LINES);
    localparam int way_w      = (`CACHE_WAYS > 1) ? $clog2(`CACHE_WAYS) : 1;
    localparam int tag_w      = `CACHE_ADDR_W - 2 - index_w - offset_w;

    typedef logic [31:0]                  word_t;
    typedef logic [`CACHE_ADDR_W-3:0]     waddr_t;
    typedef logic [offset_w-1:0]          offset_t;
    typedef logic [index_w-1:0]           index_t;
    typedef logic [tag_w-1:0]             tag_t;
    typedef logic [way_w-1:0]             way_t;
    typedef logic [index_w+offset_w-1:0]  cm_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // Victim pointer sits above the per-way entries.
    typedef struct packed {
        way_t                  victim;
        tag_entry_t [ways-1:0] way;
    } tag_row_t;

    typedef word_t [ways-1:0] data_row_t;

    typedef enum logic [1:0] {
        s_sweep,
        s_idle,
        s_wb,
        s_fill
    } ctrl_state_t;

    // Word address layout is {tag, index, offset}.
    function automatic tag_t addr_tag(waddr_t a);
        return a[$bits(waddr_t)-1 -: tag_w];
    endfunction

    function automatic index_t addr_index(waddr_t a);
        return a[offset_w +: index_w];
    endfunction

    function automatic offset_t addr_offset(waddr_t a);
        return a[offset_w-1:0];
    endfunction

endpackage

/* rtl/tag_if.sv */
// Lookup and update channel between the cache controller and the tag store.

`timescale 1ns/1ps

interface tag_if;
    import cache_pkg::*;

    // Driven by the controller.
    index_t     lookup_index;
    tag_t       cmp_tag;
    logic       upd_en;
    index_t     upd_index;
    way_t       upd_way;
    tag_entry_t upd_entry;
    logic       upd_advance;
    logic       clear_en;

    // Driven by the tag store, from the row held one cycle after lookup.
    logic       hit;
    way_t       hit_way;
    way_t       victim_way;
    tag_entry_t victim_entry;

    modport store (
        input  lookup_index, cmp_tag, upd_en, upd_index, upd_way, upd_entry,
        input  upd_advance, clear_en,
        output hit, hit_way, victim_way, victim_entry
    );

    modport ctrl (
        output lookup_index, cmp_tag, upd_en, upd_index, upd_way, upd_entry,
        output upd_advance, clear_en,
        input  hit, hit_way, victim_way, victim_entry
    );

endinterface

/* rtl/sdp_ram.sv */
// Simple dual-port RAM with registered read, shared by the tag and data stores.

`timescale 1ns/1ps

module sdp_ram #(
    parameter type row_t = logic [31:0],
    parameter int  depth = 16
) (
    input  logic                     clk,
    input  row_t                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  row_t                     wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output row_t                     rdata
);

    localparam int row_w = $bits(row_t);

    logic [row_w-1:0] mem [depth];
    logic [row_w-1:0] we_bits;
    logic [row_w-1:0] wdata_bits;

    // Rows are handled as flat bit vectors.
    assign we_bits    = we;
    assign wdata_bits = wdata;

    // Bit write enables let one lane of a row change alone.
    // Read returns the old row on a same-address write.
    always_ff @(posedge clk) begin
        for (int b = 0; b < row_w; b++) begin
            if (we_bits[b]) begin
                mem[waddr][b] <= wdata_bits[b];
            end
        end
        rdata <= row_t'(mem[raddr]);
    end

endmodule

/* rtl/cache_tag_store.sv */
// Tag RAM with hit compare, victim lookup and row update merge for the cache controller.

`timescale 1ns/1ps

module cache_tag_store (
    input  logic clk,
    tag_if.store tags
);
    import cache_pkg::*;

    tag_row_t        ram_rdata;
    tag_row_t        row;
    tag_row_t        upd_row;
    tag_row_t        wr_row;
    tag_row_t        wr_mask;
    logic            wr_en;
    logic            byp_valid;
    tag_row_t        byp_row;
    logic [ways-1:0] match;

    assign wr_en   = tags.upd_en || tags.clear_en;
    assign wr_mask = tag_row_t'({$bits(tag_row_t){wr_en}});

    sdp_ram #(
        .row_t (tag_row_t),
        .depth (lines)
    ) u_ram (
        .clk   (clk),
        .we    (wr_mask),
        .waddr (tags.upd_index),
        .wdata (wr_row),
        .raddr (tags.lookup_index),
        .rdata (ram_rdata)
    );

    // The RAM reads old data on a collision, so forward the row just written.
    always_ff @(posedge clk) begin
        byp_valid <= wr_en && (tags.upd_index == tags.lookup_index);
        byp_row   <= wr_row;
    end

    assign row = byp_valid ? byp_row : ram_rdata;

    // Per-way compare.
    always_comb begin
        tags.hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            match[w] = row.way[w].valid && (row.way[w].tag == tags.cmp_tag);
            if (match[w]) begin
                tags.hit_way = way_t'(w);
            end
        end
    end

    assign tags.hit          = |match;
    assign tags.victim_way   = row.victim;
    assign tags.victim_entry = row.way[row.victim];

    // Merge one way into the held row, optionally stepping the victim.
    always_comb begin
        upd_row = row;
        upd_row.way[tags.upd_way] = tags.upd_entry;
        if (tags.upd_advance) begin
            upd_row.victim = (row.victim == way_t'(ways - 1)) ? '0 : row.victim + 1'b1;
        end
    end

    // A cleared row is all invalid with the pointer at way 0.
    assign wr_row = tags.clear_en ? tag_row_t'(0) : upd_row;

endmodule

/* rtl/cache_data_store.sv */
// Data RAM for all cache ways; writes one way per cycle and returns every way on read.

`timescale 1ns/1ps

module cache_data_store (
    input  logic                 clk,
    input  logic                 we,
    input  cache_pkg::way_t      way,
    input  cache_pkg::cm_addr_t  waddr,
    input  cache_pkg::cm_addr_t  raddr,
    input  cache_pkg::word_t     wdata,
    output cache_pkg::data_row_t rdata
);
    import cache_pkg::*;

    data_row_t lane_we;
    data_row_t row_wdata;

    // Same word offered to all ways; only the selected lane is enabled.
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            lane_we[w]   = {$bits(word_t){we && (way == way_t'(w))}};
            row_wdata[w] = wdata;
        end
    end

    sdp_ram #(
        .row_t (data_row_t),
        .depth (lines * line_words)
    ) u_ram (
        .clk   (clk),
        .we    (lane_we),
        .waddr (waddr),
        .wdata (row_wdata),
        .raddr (raddr),
        .rdata (rdata)
    );

endmodule

/* rtl/cache_controller.sv */
// Cache sequencer: access buffer, tag sweep after reset, and writeback and fill over the memory bus.

`timescale 1ns/1ps

module cache_controller (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cpu_re,
    input  logic                 cpu_we,
    input  cache_pkg::waddr_t    cpu_addr,
    input  cache_pkg::word_t     cpu_wdata,
    output cache_pkg::word_t     cpu_rdata,
    output logic                 cpu_ready,
    output logic                 mem_re,
    output logic                 mem_we,
    output cache_pkg::waddr_t    mem_addr,
    output cache_pkg::word_t     mem_wdata,
    input  cache_pkg::word_t     mem_rdata,
    tag_if.ctrl                  tags,
    output logic                 dm_we,
    output cache_pkg::way_t      dm_way,
    output cache_pkg::cm_addr_t  dm_waddr,
    output cache_pkg::cm_addr_t  dm_raddr,
    output cache_pkg::word_t     dm_wdata,
    input  cache_pkg::data_row_t dm_rdata
);
    import cache_pkg::*;

    ctrl_state_t         state;
    index_t              sweep_idx;
    logic                ab_valid;
    logic                ab_we;
    waddr_t              ab_addr;
    word_t               ab_wdata;
    index_t              ab_index;
    tag_t                ab_tag;
    offset_t             ab_offset;
    logic [offset_w:0]   mem_cnt;
    logic [offset_w:0]   cm_cnt;
    logic                rd_pending;
    way_t                xm_way;
    tag_t                xm_tag;
    logic                cpu_req;
    logic                lookup;
    logic                write_hit;
    logic                do_miss;
    logic                victim_dirty;
    logic                wb_start;
    logic                wb_last;
    logic                fill_issue;
    logic                fill_last;
    logic                relook;

    assign ab_index  = addr_index(ab_addr);
    assign ab_tag    = addr_tag(ab_addr);
    assign ab_offset = addr_offset(ab_addr);
    assign cpu_req   = cpu_re || cpu_we;

    assign lookup       = (state == s_idle) && ab_valid;
    assign write_hit    = lookup && tags.hit && ab_we;
    assign do_miss      = lookup && !tags.hit;
    assign victim_dirty = tags.victim_entry.valid && tags.victim_entry.dirty;
    assign wb_start     = do_miss && victim_dirty;
    assign wb_last      = (state == s_wb) && (mem_cnt[offset_w-1:0] == '1);
    assign fill_issue   = (state == s_fill) && !mem_cnt[offset_w];
    assign fill_last    = rd_pending && (cm_cnt[offset_w-1:0] == '1);
    // All words are in; this cycle re-reads the line for the repeated lookup.
    assign relook       = (state == s_fill) && cm_cnt[offset_w];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= s_sweep;
            sweep_idx  <= '0;
            ab_valid   <= 1'b0;
            ab_we      <= 1'b0;
            mem_cnt    <= '0;
            cm_cnt     <= '0;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= fill_issue;
            case (state)
                s_sweep: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (sweep_idx == index_t'(lines - 1)) begin
                        state <= s_idle;
                    end
                end
                s_idle: begin
                    if (!ab_valid) begin
                        ab_valid <= cpu_req;
                        ab_we    <= cpu_we;
                    end else if (tags.hit) begin
                        ab_valid <= 1'b0;
                    end else begin
                        // Dirty victim reads word 0 now, so the cache counter starts at 1.
                        mem_cnt <= '0;
                        cm_cnt  <= {{offset_w{1'b0}}, victim_dirty};
                        state   <= victim_dirty ? s_wb : s_fill;
                    end
                end
                s_wb: begin
                    mem_cnt <= mem_cnt + 1'b1;
                    cm_cnt  <= cm_cnt + 1'b1;
                    if (wb_last) begin
                        mem_cnt <= '0;
                        cm_cnt  <= '0;
                        state   <= s_fill;
                    end
                end
                s_fill: begin
                    if (fill_issue) begin
                        mem_cnt <= mem_cnt + 1'b1;
                    end
                    if (rd_pending) begin
                        cm_cnt <= cm_cnt + 1'b1;
                    end
                    if (relook) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == s_idle) && !ab_valid) begin
            ab_addr  <= cpu_addr;
            ab_wdata <= cpu_wdata;
        end
        if (do_miss) begin
            xm_way <= tags.victim_way;
            xm_tag <= tags.victim_entry.tag;
        end
    end

    // Tag lookup follows the buffer once it holds a request.
    assign tags.lookup_index = ab_valid ? ab_index : addr_index(cpu_addr);
    assign tags.cmp_tag      = ab_tag;

    always_comb begin
        tags.upd_en      = 1'b0;
        tags.upd_index   = ab_index;
        tags.upd_way     = tags.hit_way;
        tags.upd_entry   = '{valid: 1'b1, dirty: 1'b1, tag: ab_tag};
        tags.upd_advance = 1'b0;
        tags.clear_en    = 1'b0;
        if (state == s_sweep) begin
            tags.clear_en  = 1'b1;
            tags.upd_index = sweep_idx;
        end else if (write_hit) begin
            tags.upd_en = 1'b1;
        end else if (wb_start) begin
            // Victim keeps its tag but is clean once written back.
            tags.upd_en    = 1'b1;
            tags.upd_way   = tags.victim_way;
            tags.upd_entry = '{valid: 1'b1, dirty: 1'b0, tag: tags.victim_entry.tag};
        end else if (fill_last) begin
            tags.upd_en      = 1'b1;
            tags.upd_way     = xm_way;
            tags.upd_entry   = '{valid: 1'b1, dirty: 1'b0, tag: ab_tag};
            tags.upd_advance = 1'b1;
        end
    end

    // Data RAM writes come from a write hit or a returning fill word.
    assign dm_we    = write_hit || rd_pending;
    assign dm_way   = rd_pending ? xm_way : tags.hit_way;
    assign dm_waddr = rd_pending ? {ab_index, cm_cnt[offset_w-1:0]} : {ab_index, ab_offset};
    assign dm_wdata = rd_pending ? mem_rdata : ab_wdata;

    always_comb begin
        if (wb_start) begin
            dm_raddr = {ab_index, offset_t'(0)};
        end else if (state == s_wb) begin
            dm_raddr = {ab_index, cm_cnt[offset_w-1:0]};
        end else if (ab_valid) begin
            dm_raddr = {ab_index, ab_offset};
        end else begin
            dm_raddr = {addr_index(cpu_addr), addr_offset(cpu_addr)};
        end
    end

    assign mem_we    = (state == s_wb);
    assign mem_re    = fill_issue;
    assign mem_addr  = mem_we ? {xm_tag, ab_index, mem_cnt[offset_w-1:0]}
                              : {ab_tag, ab_index, mem_cnt[offset_w-1:0]};
    assign mem_wdata = dm_rdata[xm_way];

    // Idle with no request, or a buffered request that hits.
    assign cpu_ready = (state == s_idle) && (ab_valid ? tags.hit : !cpu_req);
    assign cpu_rdata = dm_rdata[tags.hit_way];

endmodule

/* rtl/cache_top.sv */
// Cache top level with plain processor and external memory ports.

`timescale 1ns/1ps

module cache_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cpu_re,
    input  logic              cpu_we,
    input  cache_pkg::waddr_t cpu_addr,
    input  cache_pkg::word_t  cpu_wdata,
    output cache_pkg::word_t  cpu_rdata,
    output logic              cpu_ready,
    output logic              mem_re,
    output logic              mem_we,
    output cache_pkg::waddr_t mem_addr,
    output cache_pkg::word_t  mem_wdata,
    input  cache_pkg::word_t  mem_rdata
);
    import cache_pkg::*;

    logic      dm_we;
    way_t      dm_way;
    cm_addr_t  dm_waddr;
    cm_addr_t  dm_raddr;
    word_t     dm_wdata;
    data_row_t dm_rdata;

    tag_if tags ();

    cache_tag_store u_tag_store (
        .clk  (clk),
        .tags (tags.store)
    );

    cache_data_store u_data_store (
        .clk   (clk),
        .we    (dm_we),
        .way   (dm_way),
        .waddr (dm_waddr),
        .raddr (dm_raddr),
        .wdata (dm_wdata),
        .rdata (dm_rdata)
    );

    cache_controller u_controller (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_re    (cpu_re),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_ready (cpu_ready),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .tags      (tags.ctrl),
        .dm_we     (dm_we),
        .dm_way    (dm_way),
        .dm_waddr  (dm_waddr),
        .dm_raddr  (dm_raddr),
        .dm_wdata  (dm_wdata),
        .dm_rdata  (dm_rdata)
    );

endmodule

/* sim/cache_properties.sv */
// Bus strobe assertions for the cache top level, attached to it by bind.

`timescale 1ns/1ps

module cache_properties (
    input logic clk,
    input logic arst_n,
    input logic mem_re,
    input logic mem_we,
    input logic cpu_ready
);

    // Memory reads and writes never go out together.
    a_one_strobe: assert property (
        @(posedge clk) disable iff (!arst_n) !(mem_re && mem_we)
    ) else $error("mem_re and mem_we high in the same cycle");

    // The processor waits while the memory bus is busy.
    a_stall_on_mem: assert property (
        @(posedge clk) disable iff (!arst_n) (mem_re || mem_we) |-> !cpu_ready
    ) else $error("cpu_ready high during a memory strobe");

    // Quiet memory bus while reset is held.
    a_reset_quiet: assert property (
        @(posedge clk) !arst_n |-> !(mem_re || mem_we)
    ) else $error("memory strobe high during reset");

endmodule

bind cache_top cache_properties u_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_re    (mem_re),
    .mem_we    (mem_we),
    .cpu_ready (cpu_ready)
);

/* sim/cache_tb.sv */
// Cache testbench that runs a stimulus table against a memory model and a shadow copy.

`timescale 1ns/1ps

`include "cache_defines.svh"

module cache_tb;
    import cache_pkg::*;

    typedef struct {
        logic   write;
        waddr_t addr;
        word_t  wdata;
        int     reads;
        int     writes;
    } step_t;

    localparam int n_steps   = 20;
    localparam int mem_words = 2 ** (`CACHE_ADDR_W - 2);
    localparam int off_bits  = $clog2(`CACHE_LINE_WORDS);
    localparam int idx_bits  = $clog2(`CACHE_LINES);
    localparam int timeout_cycles = n_steps * (2 * `CACHE_LINE_WORDS + 8) + `CACHE_LINES + 100;

    logic   clk;
    logic   arst_n;
    logic   cpu_re;
    logic   cpu_we;
    waddr_t cpu_addr;
    word_t  cpu_wdata;
    word_t  cpu_rdata;
    logic   cpu_ready;
    logic   mem_re;
    logic   mem_we;
    waddr_t mem_addr;
    word_t  mem_wdata;
    word_t  mem_rdata;

    word_t  ext_mem [mem_words];
    word_t  shadow  [mem_words];
    step_t  steps   [n_steps];
    waddr_t cur_addr;
    int     reads_seen;
    int     writes_seen;
    int     checks;
    int     errors;

    cache_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_re    (cpu_re),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_ready (cpu_ready),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Word address layout is {tag, index, offset}.
    function automatic waddr_t make_addr(input int t, input int i, input int o);
        return {tag_t'(t), index_t'(i), offset_t'(o)};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] t=%0d ns: %s: got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Each data bit takes one LFSR step; the address is mixed in.
    task automatic fill_memory();
        logic [31:0] lfsr;
        word_t       w;
        lfsr = 32'h3358;
        for (int a = 0; a < mem_words; a++) begin
            for (int b = 0; b < 32; b++) begin
                lfsr = lfsr_step(lfsr);
                w    = {w[30:0], lfsr[0]};
            end
            ext_mem[waddr_t'(a)] = w ^ word_t'(a);
            shadow[waddr_t'(a)]  = w ^ word_t'(a);
        end
    endtask

    // External memory model where writes land at once and read data follows a cycle later.
    initial begin : memory_model
        word_t rd_word;
        logic  rd_pend;
        forever begin
            @(negedge clk);
            rd_pend = mem_re;
            rd_word = ext_mem[mem_addr];
            if (mem_re) begin
                check_value("fill line", 32'(mem_addr >> off_bits), 32'(cur_addr >> off_bits));
                check_value("fill word order", 32'(mem_addr[off_bits-1:0]),
                            32'(reads_seen % `CACHE_LINE_WORDS));
                reads_seen++;
            end
            if (mem_we) begin
                check_value("writeback before refill", 32'(reads_seen), 32'd0);
                check_value("writeback set", 32'(mem_addr[off_bits +: idx_bits]),
                            32'(cur_addr[off_bits +: idx_bits]));
                check_value("writeback word order", 32'(mem_addr[off_bits-1:0]),
                            32'(writes_seen % `CACHE_LINE_WORDS));
                check_value("writeback data", mem_wdata, shadow[mem_addr]);
                ext_mem[mem_addr] = mem_wdata;
                writes_seen++;
            end
            @(posedge clk);
            #2;
            if (rd_pend) begin
                mem_rdata = rd_word;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles, %0d errors so far", cycles, errors);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        word_t got;
        int    sweep_cycles;
        arst_n      = 1'b0;
        cpu_re      = 1'b0;
        cpu_we      = 1'b0;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        mem_rdata   = '0;
        cur_addr    = '0;
        reads_seen  = 0;
        writes_seen = 0;
        checks      = 0;
        errors      = 0;
        fill_memory();

        // Set 0 basic hits, set 1 dirty evictions, set 2 clean evictions.
        steps[0]  = '{1'b0, make_addr(5, 0, 1), 32'h0, 4, 0};
        steps[1]  = '{1'b1, make_addr(5, 0, 1), 32'ha5a5_0001, 0, 0};
        steps[2]  = '{1'b0, make_addr(5, 0, 1), 32'h0, 0, 0};
        steps[3]  = '{1'b0, make_addr(5, 0, 3), 32'h0, 0, 0};
        steps[4]  = '{1'b1, make_addr(16, 1, 2), 32'h1111_2222, 4, 0};
        steps[5]  = '{1'b1, make_addr(17, 1, 0), 32'h3333_4444, 4, 0};
        steps[6]  = '{1'b0, make_addr(18, 1, 1), 32'h0, 4, 4};
        steps[7]  = '{1'b0, make_addr(16, 1, 2), 32'h0, 4, 4};
        steps[8]  = '{1'b0, make_addr(32, 2, 0), 32'h0, 4, 0};
        steps[9]  = '{1'b0, make_addr(33, 2, 3), 32'h0, 4, 0};
        steps[10] = '{1'b0, make_addr(34, 2, 2), 32'h0, 4, 0};
        steps[11] = '{1'b0, make_addr(32, 2, 0), 32'h0, 4, 0};
        steps[12] = '{1'b0, make_addr(34, 2, 2), 32'h0, 0, 0};
        steps[13] = '{1'b0, make_addr(17, 1, 0), 32'h0, 4, 0};
        steps[14] = '{1'b1, make_addr(5, 0, 1), 32'ha5a5_0002, 0, 0};
        steps[15] = '{1'b1, make_addr(6, 0, 0), 32'h6666_0000, 4, 0};
        steps[16] = '{1'b1, make_addr(7, 0, 2), 32'h7777_0002, 4, 4};
        steps[17] = '{1'b0, make_addr(5, 0, 1), 32'h0, 4, 4};
        steps[18] = '{1'b0, make_addr(6, 0, 0), 32'h0, 4, 4};
        steps[19] = '{1'b0, make_addr(7, 0, 2), 32'h0, 4, 0};

        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Tag sweep clears one set per cycle before the first ready.
        sweep_cycles = 0;
        @(negedge clk);
        while (!cpu_ready) begin
            sweep_cycles++;
            @(negedge clk);
        end
        check_value("sweep cycles", 32'(sweep_cycles), 32'(`CACHE_LINES));
        check_value("memory activity before first request", 32'(reads_seen + writes_seen), 32'd0);
        @(posedge clk);
        #2;

        for (int i = 0; i < n_steps; i++) begin
            cur_addr    = steps[i].addr;
            reads_seen  = 0;
            writes_seen = 0;
            cpu_re      = !steps[i].write;
            cpu_we      = steps[i].write;
            cpu_addr    = steps[i].addr;
            cpu_wdata   = steps[i].wdata;
            @(negedge clk);
            while (!cpu_ready) begin
                @(negedge clk);
            end
            got = cpu_rdata;
            @(posedge clk);
            if (steps[i].write) begin
                shadow[steps[i].addr] = steps[i].wdata;
            end else begin
                check_value("read data", got, shadow[steps[i].addr]);
            end
            check_value("memory reads", 32'(reads_seen), 32'(steps[i].reads));
            check_value("memory writes", 32'(writes_seen), 32'(steps[i].writes));
            #2;
        end
        cpu_re = 1'b0;
        cpu_we = 1'b0;
        repeat (2) @(posedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/tag_if.sv
rtl/sdp_ram.sv
rtl/cache_tag_store.sv
rtl/cache_data_store.sv
rtl/cache_controller.sv
rtl/cache_top.sv
sim/cache_properties.sv
sim/cache_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f all.f -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    && ! grep -q "RESULT: FAIL" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
